/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = api_tb
FILELIST  = project.f
SRCS      = $(shell grep -v '^+' $(FILELIST)) api_defines.svh
BIN       = obj_dir/V$(TOP)
LOG       = sim.log

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qxF '** PASS **' $(LOG)

check: run
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

/* api_assert.sv */
`timescale 1ns/100ps
`include "api_defines.svh"

module api_assert (
        input logic                clk,
        input logic                rst,
        input api_pkg::wb_rsp_t    wb_rsp,
        input logic                tx_push,
        input api_pkg::fifo_stat_t tx_stat,
        input logic                rx_push,
        input api_pkg::fifo_stat_t rx_stat,
        input logic                flush
);
        // Single-cycle ack
        ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
                wb_rsp.ack |=> !wb_rsp.ack)
                else $error("ack high in two consecutive cycles");

        tx_push_room: assert property (@(posedge clk) disable iff (rst)
                tx_push |-> !tx_stat.full)
                else $error("tx_push while tx FIFO full");

        rx_push_room: assert property (@(posedge clk) disable iff (rst)
                rx_push |-> !rx_stat.full)
                else $error("rx_push while rx FIFO full");

        // Pulse ends after exactly API_FLUSH_LEN cycles high
        flush_length: assert property (@(posedge clk) disable iff (rst)
                $fell(flush) |-> $past(flush, 2) && $past(flush, 3) && $past(flush, 4)
                                 && !$past(flush, 5))
                else $error("flush pulse length is not 4 cycles");

endmodule

bind api_top api_assert u_assert (
        .clk(clk), .rst(rst), .wb_rsp(wb_rsp), .tx_push(tx_push), .tx_stat(tx_stat),
        .rx_push(rx_push), .rx_stat(rx_stat), .flush(flush)
);

/* api_defines.svh */
`ifndef API_DEFINES_SVH
`define API_DEFINES_SVH

// Bus widths
`define API_DW          32
`define API_AW          6

// FIFO sizing, count must hold DEPTH itself
`define API_FIFO_DEPTH  16
`define API_CNT_W       5

// Register map
`define API_ADR_TXFIFO  6'h00
`define API_ADR_RXFIFO  6'h04
`define API_ADR_STATUS  6'h08
`define API_ADR_SCK     6'h0C

`define API_EMPTY_MARK  32'h12345678    // Rx port read while rx FIFO empty
`define API_BAD_ADDR    32'hDEADDEAD    // Unmapped address

`define API_FLUSH_LEN   4               // Flush pulse in cycles

`endif

/* api_pkg.sv */
`include "api_defines.svh"

package api_pkg;

        // Register offsets
        typedef enum logic [`API_AW-1:0] {
                REG_TXFIFO = `API_ADR_TXFIFO,
                REG_RXFIFO = `API_ADR_RXFIFO,
                REG_STATUS = `API_ADR_STATUS,
                REG_SCK    = `API_ADR_SCK
        } api_reg_e;

        typedef enum logic [1:0] {IDLE, LOAD, SHIFT, STORE} link_state_e;

        // Host to slave
        typedef struct packed {
                logic               cyc;
                logic               stb;
                logic               we;
                logic [`API_AW-1:0] adr;
                logic [`API_DW-1:0] dat;
        } wb_req_t;

        typedef struct packed {
                logic               ack;
                logic [`API_DW-1:0] dat;
        } wb_rsp_t;

        typedef struct packed {
                logic [`API_CNT_W-1:0] count;
                logic                  empty;
                logic                  full;
        } fifo_stat_t;

endpackage

/* api_slave.sv */
`timescale 1ns/100ps
`include "api_defines.svh"

module api_slave (
        input  logic                clk,
        input  logic                rst,
        input  api_pkg::wb_req_t    wb_req,
        output api_pkg::wb_rsp_t    wb_rsp,
        output logic                tx_push,
        output logic [`API_DW-1:0]  tx_din,
        input  api_pkg::fifo_stat_t tx_stat,
        output logic                rx_pop,
        input  logic [`API_DW-1:0]  rx_dout,
        input  api_pkg::fifo_stat_t rx_stat,
        input  logic                link_busy,
        output logic                flush,
        output logic [7:0]          sck_div
);
        import api_pkg::*;

        logic                      ack;
        logic [`API_DW-1:0]        rd_dat;
        logic                      req_new;
        logic                      wr_tx;
        logic                      wr_stat;
        logic                      wr_sck;
        logic                      rd_rx;
        logic [`API_DW-1:0]        rd_mux;
        logic [`API_DW-1:0]        stat_word;
        logic [`API_FLUSH_LEN-1:0] flush_sr;

        // First cycle of a request only, ack blocks a second hit
        assign req_new = wb_req.cyc && wb_req.stb && !ack;

        // Status layout, 14 bits used
        assign stat_word = {{(`API_DW - 14){1'b0}},
                            rx_stat.count, rx_stat.empty, link_busy,
                            tx_stat.count, flush, tx_stat.full};

        // --------------------
        // Address decode
        // --------------------
        always_comb begin
                wr_tx   = 1'b0;
                wr_stat = 1'b0;
                wr_sck  = 1'b0;
                rd_rx   = 1'b0;
                rd_mux  = `API_BAD_ADDR;
                case (api_reg_e'(wb_req.adr))
                REG_TXFIFO: begin
                        wr_tx  = wb_req.we;
                        rd_mux = {{(`API_DW - `API_CNT_W){1'b0}}, tx_stat.count};
                end
                REG_RXFIFO: begin
                        rd_rx  = !wb_req.we;
                        rd_mux = rx_stat.empty ? `API_EMPTY_MARK : rx_dout;
                end
                REG_STATUS: begin
                        wr_stat = wb_req.we;
                        rd_mux  = stat_word;
                end
                REG_SCK: begin
                        wr_sck = wb_req.we;
                        rd_mux = {{(`API_DW - 8){1'b0}}, sck_div};
                end
                default: ;                      // Unmapped keeps the bad-address word
                endcase
        end

        // --------------------
        // Control registers
        // --------------------
        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        ack      <= 1'b0;
                        tx_push  <= 1'b0;
                        flush_sr <= '0;
                        sck_div  <= 8'd1;
                end else begin
                        ack     <= req_new;
                        tx_push <= req_new && wr_tx && !tx_stat.full;   // Full drops the word
                        // Only bit 1 of a status write does anything
                        if (req_new && wr_stat && wb_req.dat[1])
                                flush_sr <= {{(`API_FLUSH_LEN - 1){1'b0}}, 1'b1};
                        else
                                flush_sr <= flush_sr << 1;
                        if (req_new && wr_sck)
                                sck_div <= wb_req.dat[7:0];
                end
        end

        // Write word and read data, captured with the request
        always_ff @(posedge clk) begin
                if (req_new) begin
                        tx_din <= wb_req.dat;
                        rd_dat <= rd_mux;
                end
        end

        assign flush  = |flush_sr;              // High while the marker walks through
        assign rx_pop = req_new && rd_rx && !rx_stat.empty;
        assign wb_rsp = '{ack: ack, dat: rd_dat};

endmodule

/* api_tb.sv */
`timescale 1ns/100ps
`include "api_defines.svh"

module api_tb;
        import api_pkg::*;

        localparam int ACK_LIMIT  = 20;         // Cycles per bus cycle
        localparam int POLL_LIMIT = 4000;       // Status reads per wait

        typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_SEND, OP_RECV, OP_SETTLE, OP_FLUSH} op_e;

        logic        clk;
        logic        rst;
        wb_req_t     wb_req;
        wb_rsp_t     wb_rsp;
        logic        sck;
        logic        sdo;

        // Stimulus table
        string       t_name[$];
        op_e         t_op[$];
        logic [5:0]  t_adr[$];
        logic [31:0] t_dat[$];
        logic [31:0] t_exp[$];
        bit          t_wait[$];

        logic [31:0] sent_q[$];                 // Words in flight with the oldest first
        logic [31:0] lcg_state;
        logic [31:0] rdata;
        logic [7:0]  exp_div;                   // Divider last written
        int          sck_run;                   // Clocks with sck high
        int          check_cnt;
        int          err_cnt;
        int          timeout_cnt;

        api_top uut (
                .clk(clk), .rst(rst), .wb_req(wb_req), .wb_rsp(wb_rsp),
                .sck(sck), .sdo(sdo), .sdi(sdo)        // Loopback
        );

        always #5 clk = ~clk;

        function automatic logic [31:0] lcg_next(input logic [31:0] s);
                return s * 32'd1103515245 + 32'd12345;
        endfunction

        // Expected status register from its field layout
        function automatic logic [31:0] status_word(input bit tx_full, input bit flsh,
                                                    input int tx_cnt, input bit busy,
                                                    input bit rx_empty, input int rx_cnt);
                logic [31:0] s;
                s = '0;
                s[0]    = tx_full;
                s[1]    = flsh;
                s[6:2]  = tx_cnt[4:0];
                s[7]    = busy;
                s[8]    = rx_empty;
                s[13:9] = rx_cnt[4:0];
                return s;
        endfunction

        task automatic add_entry(input string name, input op_e op, input logic [5:0] adr,
                                 input logic [31:0] dat, input logic [31:0] exp, input bit wt);
                t_name.push_back(name);
                t_op.push_back(op);
                t_adr.push_back(adr);
                t_dat.push_back(dat);
                t_exp.push_back(exp);
                t_wait.push_back(wt);
        endtask

        // One Wishbone classic cycle that starts and ends 1 ns after a rising edge
        task automatic bus_cycle(input logic we, input logic [5:0] adr,
                                 input logic [31:0] dat, output logic [31:0] rd);
                int n;
                rd = '0;
                wb_req.cyc = 1'b1;
                wb_req.stb = 1'b1;
                wb_req.we  = we;
                wb_req.adr = adr;
                wb_req.dat = dat;
                n = 0;
                do begin
                        @(posedge clk);
                        #1;
                        n++;
                end while (!wb_rsp.ack && n < ACK_LIMIT);
                if (wb_rsp.ack) begin
                        rd = wb_rsp.dat;
                end else begin
                        timeout_cnt++;
                        $display("Timeout: no ack for access to address %02h", adr);
                end
                wb_req = '0;
        endtask

        // Poll status until one bit takes a value
        task automatic wait_status(input int idx, input logic val, input string what);
                logic [31:0] s;
                int n;
                n = 0;
                do begin
                        bus_cycle(1'b0, `API_ADR_STATUS, '0, s);
                        n++;
                end while (s[idx] !== val && n < POLL_LIMIT && timeout_cnt == 0);
                if (s[idx] !== val && timeout_cnt == 0) begin
                        timeout_cnt++;
                        $display("Timeout waiting for %s", what);
                end
        endtask

        // Link idle and status unchanged over two reads
        task automatic wait_settled();
                logic [31:0] prev;
                logic [31:0] cur;
                bit stable;
                int n;
                bus_cycle(1'b0, `API_ADR_STATUS, '0, prev);
                n = 0;
                do begin
                        bus_cycle(1'b0, `API_ADR_STATUS, '0, cur);
                        n++;
                        stable = !cur[7] && (cur == prev);
                        prev = cur;
                end while (!stable && n < POLL_LIMIT && timeout_cnt == 0);
                if (!stable && timeout_cnt == 0) begin
                        timeout_cnt++;
                        $display("Timeout waiting for the link to settle");
                end
        endtask

        task automatic check_value(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
                check_cnt++;
                if (act !== exp) begin
                        err_cnt++;
                        $display("Mismatch %s: expected %08h, actual %08h", name, exp, act);
                end
        endtask

        // --------------------
        // sck high phase is sck_div + 1 clocks
        always @(negedge clk) begin
                if (rst) begin
                        sck_run = 0;
                end else if (sck) begin
                        sck_run++;
                end else if (sck_run != 0) begin
                        check_value("sck_high", {24'd0, exp_div} + 32'd1, sck_run);
                        sck_run = 0;
                end
        end

        task automatic build_table();
                logic [31:0] divs [5];
                logic [31:0] idle_stat;
                divs[0] = 32'd0;
                divs[1] = 32'd2;
                divs[2] = 32'd5;
                divs[3] = 32'd37;
                divs[4] = 32'hFFFF_FF09;        // Upper bits ignored
                idle_stat = status_word(0, 0, 0, 0, 1, 0);
                // --------------------
                // Reset values
                add_entry("reset_status", OP_READ, `API_ADR_STATUS, 0, idle_stat, 0);
                add_entry("reset_sck", OP_READ, `API_ADR_SCK, 0, 32'd1, 0);
                add_entry("reset_rx_port", OP_READ, `API_ADR_RXFIFO, 0, `API_EMPTY_MARK, 0);
                add_entry("reset_tx_count", OP_READ, `API_ADR_TXFIFO, 0, 32'd0, 0);
                // --------------------
                for (int k = 0; k < 6; k++) begin
                        add_entry($sformatf("loop_send_%0d", k), OP_SEND, 0, 0, 0, 0);
                        add_entry($sformatf("loop_recv_%0d", k), OP_RECV, 0, 0, 0, 1);
                end
                add_entry("loop_drained", OP_READ, `API_ADR_RXFIFO, 0, `API_EMPTY_MARK, 0);
                foreach (divs[k]) begin
                        add_entry($sformatf("div_set_%0d", k), OP_WRITE, `API_ADR_SCK, divs[k], 0, 0);
                        add_entry($sformatf("div_read_%0d", k), OP_READ, `API_ADR_SCK, 0,
                                  {24'd0, divs[k][7:0]}, 0);
                        add_entry($sformatf("div_send_%0d", k), OP_SEND, 0, 0, 0, 0);
                        add_entry($sformatf("div_recv_%0d", k), OP_RECV, 0, 0, 0, 1);
                end
                // --------------------
                // Back-pressure leaves 16 words in rx and 4 in tx
                add_entry("bp_div", OP_WRITE, `API_ADR_SCK, 32'd0, 0, 0);
                for (int k = 0; k < 20; k++)
                        add_entry($sformatf("bp_send_%0d", k), OP_SEND, 0, 0, 0, 0);
                add_entry("bp_settle", OP_SETTLE, 0, 0, 0, 0);
                add_entry("bp_status", OP_READ, `API_ADR_STATUS, 0,
                          status_word(0, 0, 4, 0, 0, 16), 0);
                add_entry("bp_tx_count", OP_READ, `API_ADR_TXFIFO, 0, 32'd4, 0);
                for (int k = 0; k < 20; k++)
                        add_entry($sformatf("bp_recv_%0d", k), OP_RECV, 0, 0, 0, 1);
                add_entry("bp_drained", OP_READ, `API_ADR_RXFIFO, 0, `API_EMPTY_MARK, 0);
                // --------------------
                for (int k = 0; k < 8; k++)
                        add_entry($sformatf("fl_send_%0d", k), OP_SEND, 0, 0, 0, 0);
                add_entry("fl_flush", OP_FLUSH, `API_ADR_STATUS, 32'h2, 0, 1);
                add_entry("fl_status", OP_READ, `API_ADR_STATUS, 0, idle_stat, 0);
                add_entry("fl_rx_port", OP_READ, `API_ADR_RXFIFO, 0, `API_EMPTY_MARK, 0);
                // Unmapped addresses
                add_entry("bad_20", OP_READ, 6'h20, 0, `API_BAD_ADDR, 0);
                add_entry("bad_3c", OP_READ, 6'h3C, 0, `API_BAD_ADDR, 0);
                add_entry("final_status", OP_READ, `API_ADR_STATUS, 0, idle_stat, 0);
        endtask

        initial begin
                clk         = 1'b0;
                rst         = 1'b1;
                wb_req      = '0;
                check_cnt   = 0;
                err_cnt     = 0;
                timeout_cnt = 0;
                sck_run     = 0;
                exp_div     = 8'd1;
                lcg_state   = 32'd78448;
                build_table();
                repeat (4) @(posedge clk);
                #1;
                rst = 1'b0;
                check_value("reset_pins", 32'd0, {30'd0, sck, sdo});    // sck and sdo low

                for (int i = 0; i < t_name.size() && timeout_cnt == 0; i++) begin
                        if (t_wait[i])
                                wait_status(8, 1'b0, {"receive data in ", t_name[i]});
                        case (t_op[i])
                        OP_WRITE: begin
                                bus_cycle(1'b1, t_adr[i], t_dat[i], rdata);
                                if (t_adr[i] == `API_ADR_SCK)
                                        exp_div = t_dat[i][7:0];
                        end
                        OP_READ: begin
                                bus_cycle(1'b0, t_adr[i], 0, rdata);
                                if (timeout_cnt == 0)
                                        check_value(t_name[i], t_exp[i], rdata);
                        end
                        OP_SEND: begin
                                wait_status(0, 1'b0, {"transmit room in ", t_name[i]});
                                lcg_state = lcg_next(lcg_state);
                                sent_q.push_back(lcg_state);
                                bus_cycle(1'b1, `API_ADR_TXFIFO, lcg_state, rdata);
                        end
                        OP_RECV: begin
                                bus_cycle(1'b0, `API_ADR_RXFIFO, 0, rdata);
                                if (sent_q.size() == 0) begin
                                        err_cnt++;
                                        $display("Receive in %s with no word sent", t_name[i]);
                                end else if (timeout_cnt == 0) begin
                                        check_value(t_name[i], sent_q.pop_front(), rdata);
                                end
                        end
                        OP_SETTLE: wait_settled();
                        OP_FLUSH: begin
                                bus_cycle(1'b1, t_adr[i], t_dat[i], rdata);
                                sent_q.delete();
                                wait_status(1, 1'b0, "flush to clear");
                        end
                        default: ;
                        endcase
                end

                $display("Checks: %0d, mismatches: %0d, timeouts: %0d",
                         check_cnt, err_cnt, timeout_cnt);
                if (err_cnt == 0 && timeout_cnt == 0)
                        $display("** PASS **");
                else
                        $display("** FAIL **");
                $finish;
        end

endmodule

/* api_top.sv */
`timescale 1ns/100ps
`include "api_defines.svh"

module api_top (
        input  logic             clk,
        input  logic             rst,
        input  api_pkg::wb_req_t wb_req,
        output api_pkg::wb_rsp_t wb_rsp,
        output logic             sck,
        output logic             sdo,
        input  logic             sdi
);
        // Transmit side
        logic                tx_push;
        logic [`API_DW-1:0]  tx_din;
        logic                tx_pop;
        logic [`API_DW-1:0]  tx_dout;
        api_pkg::fifo_stat_t tx_stat;

        // Receive side
        logic                rx_push;
        logic [`API_DW-1:0]  rx_word;
        logic                rx_pop;
        logic [`API_DW-1:0]  rx_dout;
        api_pkg::fifo_stat_t rx_stat;

        logic                link_busy;
        logic                flush;
        logic [7:0]          sck_div;

        api_slave u_slave (
                .clk(clk), .rst(rst), .wb_req(wb_req), .wb_rsp(wb_rsp),
                .tx_push(tx_push), .tx_din(tx_din), .tx_stat(tx_stat),
                .rx_pop(rx_pop), .rx_dout(rx_dout), .rx_stat(rx_stat),
                .link_busy(link_busy), .flush(flush), .sck_div(sck_div)
        );

        word_fifo #(.DEPTH(`API_FIFO_DEPTH)) tx_fifo (
                .clk(clk), .rst(rst), .flush(flush), .push(tx_push), .din(tx_din),
                .pop(tx_pop), .dout(tx_dout), .stat(tx_stat)
        );

        serial_link u_link (
                .clk(clk), .rst(rst), .flush(flush), .sck_div(sck_div),
                .tx_word(tx_dout), .tx_stat(tx_stat), .rx_stat(rx_stat),
                .tx_pop(tx_pop), .rx_push(rx_push), .rx_word(rx_word),
                .busy(link_busy), .sck(sck), .sdo(sdo), .sdi(sdi)
        );

        word_fifo #(.DEPTH(`API_FIFO_DEPTH)) rx_fifo (
                .clk(clk), .rst(rst), .flush(flush), .push(rx_push), .din(rx_word),
                .pop(rx_pop), .dout(rx_dout), .stat(rx_stat)
        );

endmodule

/* project.f */
+incdir+.
api_pkg.sv
word_fifo.sv
serial_link.sv
api_slave.sv
api_top.sv
api_assert.sv
api_tb.sv

/* serial_link.sv */
`timescale 1ns/100ps
`include "api_defines.svh"

module serial_link (
        input  logic                clk,
        input  logic                rst,
        input  logic                flush,
        input  logic [7:0]          sck_div,
        input  logic [`API_DW-1:0]  tx_word,
        input  api_pkg::fifo_stat_t tx_stat,
        input  api_pkg::fifo_stat_t rx_stat,
        output logic                tx_pop,
        output logic                rx_push,
        output logic [`API_DW-1:0]  rx_word,
        output logic                busy,
        output logic                sck,
        output logic                sdo,
        input  logic                sdi
);
        import api_pkg::*;

        localparam int BW = $clog2(`API_DW);
        localparam logic [BW-1:0] LAST_BIT = BW'(`API_DW - 1);

        link_state_e        state;
        logic [7:0]         div_cnt;    // Cycles within one sck half
        logic [BW-1:0]      bit_cnt;
        logic [`API_DW-1:0] tx_shift;
        logic [`API_DW-1:0] rx_shift;
        logic               half_done;
        logic               rise_en;
        logic               fall_en;

        // Compare with >= so a smaller divider mid-word cannot wrap the counter
        assign half_done = (div_cnt >= sck_div);
        assign rise_en   = (state == SHIFT) && half_done && !sck;
        assign fall_en   = (state == SHIFT) && half_done && sck;

        // --------------------
        // Link FSM
        // --------------------
        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        state   <= IDLE;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        sck     <= 1'b0;
                end else if (flush) begin
                        state   <= IDLE;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        sck     <= 1'b0;
                end else begin
                        case (state)
                        IDLE: begin
                                // Start only with a word to send and room to keep it
                                if (!tx_stat.empty && !rx_stat.full)
                                        state <= LOAD;
                        end
                        LOAD: begin
                                state   <= SHIFT;
                                div_cnt <= '0;
                                bit_cnt <= '0;
                                sck     <= 1'b0;
                        end
                        SHIFT: begin
                                if (!half_done) begin
                                        div_cnt <= div_cnt + 1'b1;
                                end else begin
                                        div_cnt <= '0;
                                        sck     <= !sck;
                                        if (sck) begin          // Falling edge ends a bit
                                                bit_cnt <= bit_cnt + 1'b1;
                                                if (bit_cnt == LAST_BIT)
                                                        state <= STORE;
                                        end
                                end
                        end
                        STORE:   state <= IDLE;
                        default: state <= IDLE;
                        endcase
                end
        end

        // --------------------
        // Shift registers
        // --------------------
        always_ff @(posedge clk or posedge rst) begin
                if (rst)
                        tx_shift <= '0;
                else if (flush)
                        tx_shift <= '0;
                else if (state == LOAD)
                        tx_shift <= tx_word;
                else if (fall_en)
                        tx_shift <= {tx_shift[`API_DW-2:0], 1'b0};   // MSB first
        end

        always_ff @(posedge clk) begin
                if (rise_en)
                        rx_shift <= {rx_shift[`API_DW-2:0], sdi};
        end

        assign tx_pop  = (state == LOAD);
        assign rx_push = (state == STORE);
        assign rx_word = rx_shift;
        assign busy    = (state != IDLE);
        assign sdo     = tx_shift[`API_DW-1];

endmodule

/* word_fifo.sv */
`timescale 1ns/100ps
`include "api_defines.svh"

module word_fifo #(
        parameter int DEPTH = `API_FIFO_DEPTH
) (
        input  logic                clk,
        input  logic                rst,
        input  logic                flush,
        input  logic                push,
        input  logic [`API_DW-1:0]  din,
        input  logic                pop,
        output logic [`API_DW-1:0]  dout,
        output api_pkg::fifo_stat_t stat
);
        import api_pkg::*;

        localparam int PW = $clog2(DEPTH);
        localparam logic [`API_CNT_W-1:0] FULL_CNT = DEPTH[`API_CNT_W-1:0];
        localparam fifo_stat_t STAT_CLR = '{count: '0, empty: 1'b1, full: 1'b0};

        logic [`API_DW-1:0] mem [DEPTH];
        logic [PW-1:0]      wr_ptr;
        logic [PW-1:0]      rd_ptr;
        logic               do_push;
        logic               do_pop;
        fifo_stat_t         stat_next;

        assign do_push = push && !stat.full;    // Drop when full
        assign do_pop  = pop && !stat.empty;
        assign dout    = mem[rd_ptr];            // Show-ahead

        always_comb begin
                stat_next = stat;
                case ({do_push, do_pop})
                2'b10:   stat_next.count = stat.count + 1'b1;
                2'b01:   stat_next.count = stat.count - 1'b1;
                default: ;
                endcase
                stat_next.empty = (stat_next.count == '0);
                stat_next.full  = (stat_next.count == FULL_CNT);
        end

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        stat   <= STAT_CLR;
                end else if (flush) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        stat   <= STAT_CLR;
                end else begin
                        if (do_push)
                                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                        if (do_pop)
                                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                        stat <= stat_next;
                end
        end

        always_ff @(posedge clk) begin
                if (do_push)
                        mem[wr_ptr] <= din;
        end

endmodule
